// File: verilog/aluOpsPkg.sv
// ALU instruction set constants
package aluOpsPkg;

    // datapath widths
    localparam int dataWidth = 16;
    localparam int opcodeWidth = 4;
    localparam int regIdxWidth = 4;
    localparam int immWidth = 8;
    localparam int byteWidth = 8;
    localparam int nibbleWidth = 4;

    // signed byte sum needs two guard bits
    localparam int redWidth = byteWidth + 2;

    // opcode map
    localparam logic [opcodeWidth-1:0] opAdd = 4'd0;
    localparam logic [opcodeWidth-1:0] opSub = 4'd1;
    localparam logic [opcodeWidth-1:0] opXor = 4'd2;
    localparam logic [opcodeWidth-1:0] opRed = 4'd3;
    localparam logic [opcodeWidth-1:0] opSll = 4'd4;
    localparam logic [opcodeWidth-1:0] opSra = 4'd5;
    localparam logic [opcodeWidth-1:0] opRor = 4'd6;
    localparam logic [opcodeWidth-1:0] opPaddsb = 4'd7;
    localparam logic [opcodeWidth-1:0] opLlb = 4'd8;
    localparam logic [opcodeWidth-1:0] opLhb = 4'd9;
    localparam logic [opcodeWidth-1:0] opLastLegal = 4'd9;

    // saturation bounds
    localparam logic [dataWidth-1:0] satMax = 16'h7fff;
    localparam logic [dataWidth-1:0] satMin = 16'h8000;
    localparam logic [nibbleWidth-1:0] nibSatMax = 4'h7;
    localparam logic [nibbleWidth-1:0] nibSatMin = 4'h8;

    // base-3 shifter, digits weigh 1, 3 and 9
    localparam int shiftAmtWidth = 4;
    localparam int stageBase = 3;
    localparam int stageWeight0 = 1;
    localparam int stageWeight1 = 3;
    localparam int stageWeight2 = 9;
endpackage

// File: verilog/execIfPkg.sv
// Execute stage interface types
package execIfPkg;

    // opcode, rd, rs, rt
    typedef struct packed {
        logic [aluOpsPkg::opcodeWidth-1:0] opcode;
        logic [aluOpsPkg::regIdxWidth-1:0] rd;
        logic [aluOpsPkg::regIdxWidth-1:0] rs;
        logic [aluOpsPkg::regIdxWidth-1:0] rt;
    } regForm_t;

    // opcode, rd, 8-bit immediate for the byte loads
    typedef struct packed {
        logic [aluOpsPkg::opcodeWidth-1:0] opcode;
        logic [aluOpsPkg::regIdxWidth-1:0] rd;
        logic [aluOpsPkg::immWidth-1:0] imm8;
    } immForm_t;

    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } instrWord_t;

    typedef struct packed {
        instrWord_t instr;
        logic [aluOpsPkg::dataWidth-1:0] rsVal;
        logic [aluOpsPkg::dataWidth-1:0] rtVal;
    } execReq_t;

    typedef struct packed {
        logic [aluOpsPkg::dataWidth-1:0] result;
        logic sat;
        logic illegal;
    } execResp_t;

    typedef struct packed {
        logic [aluOpsPkg::dataWidth-1:0] add;
        logic [aluOpsPkg::dataWidth-1:0] sub;
        logic [aluOpsPkg::dataWidth-1:0] paddsb;
        logic [aluOpsPkg::dataWidth-1:0] red;
        logic addSat;
        logic subSat;
    } arithResults_t;

    typedef struct packed {
        logic [aluOpsPkg::dataWidth-1:0] xorv;
        logic [aluOpsPkg::dataWidth-1:0] sll;
        logic [aluOpsPkg::dataWidth-1:0] sra;
        logic [aluOpsPkg::dataWidth-1:0] ror;
        logic [aluOpsPkg::dataWidth-1:0] llb;
        logic [aluOpsPkg::dataWidth-1:0] lhb;
    } bitResults_t;

    // handshake controller states
    localparam int stateWidth = 2;
    localparam logic [stateWidth-1:0] stateIdle = 2'd0;
    localparam logic [stateWidth-1:0] stateComputing = 2'd1;
    localparam logic [stateWidth-1:0] stateAcked = 2'd2;
endpackage

// File: verilog/arithUnit.sv
// Saturating arithmetic unit
`timescale 1ns/1ps

module arithUnit (
    input  execIfPkg::execReq_t      latchedReq,
    output execIfPkg::arithResults_t arithRes
);
    localparam int msb = aluOpsPkg::dataWidth - 1;
    localparam int numNibbles = aluOpsPkg::dataWidth / aluOpsPkg::nibbleWidth;

    logic [aluOpsPkg::dataWidth-1:0] rsVal;
    logic [aluOpsPkg::dataWidth-1:0] rtVal;
    logic [aluOpsPkg::dataWidth:0] addOut;
    logic [aluOpsPkg::dataWidth:0] subOut;
    logic [aluOpsPkg::nibbleWidth-1:0] nibA;
    logic [aluOpsPkg::nibbleWidth-1:0] nibB;
    logic [aluOpsPkg::nibbleWidth-1:0] nibSum;
    logic [aluOpsPkg::dataWidth-1:0] paddsbVal;
    logic signed [aluOpsPkg::redWidth-1:0] redSum;

    // returns {overflow, clamped value}
    function automatic logic [aluOpsPkg::dataWidth:0] satAddSub(
        input logic [aluOpsPkg::dataWidth-1:0] a,
        input logic [aluOpsPkg::dataWidth-1:0] b,
        input logic subtract
    );
        logic [aluOpsPkg::dataWidth-1:0] raw;
        logic overflow;
        raw = subtract ? a - b : a + b;
        // overflow only when the effective operand signs agree
        overflow = (a[msb] == (b[msb] ^ subtract)) && (raw[msb] != a[msb]);
        if (overflow) begin
            return {1'b1, a[msb] ? aluOpsPkg::satMin : aluOpsPkg::satMax};
        end
        return {1'b0, raw};
    endfunction

    assign rsVal = latchedReq.rsVal;
    assign rtVal = latchedReq.rtVal;

    assign addOut = satAddSub(rsVal, rtVal, 1'b0);
    assign subOut = satAddSub(rsVal, rtVal, 1'b1);

    // four independent signed nibble adds
    always_comb begin
        paddsbVal = '0;
        for (int i = 0; i < numNibbles; i++) begin
            nibA = rsVal[i*aluOpsPkg::nibbleWidth +: aluOpsPkg::nibbleWidth];
            nibB = rtVal[i*aluOpsPkg::nibbleWidth +: aluOpsPkg::nibbleWidth];
            nibSum = nibA + nibB;
            if (nibA[3] == nibB[3] && nibSum[3] != nibA[3]) begin
                nibSum = nibA[3] ? aluOpsPkg::nibSatMin : aluOpsPkg::nibSatMax;
            end
            paddsbVal[i*aluOpsPkg::nibbleWidth +: aluOpsPkg::nibbleWidth] = nibSum;
        end
    end

    // sum of all four signed bytes, never overflows
    assign redSum = $signed(rsVal[msb:aluOpsPkg::byteWidth])
                  + $signed(rsVal[aluOpsPkg::byteWidth-1:0])
                  + $signed(rtVal[msb:aluOpsPkg::byteWidth])
                  + $signed(rtVal[aluOpsPkg::byteWidth-1:0]);

    always_comb begin
        arithRes.add = addOut[aluOpsPkg::dataWidth-1:0];
        arithRes.addSat = addOut[aluOpsPkg::dataWidth];
        arithRes.sub = subOut[aluOpsPkg::dataWidth-1:0];
        arithRes.subSat = subOut[aluOpsPkg::dataWidth];
        arithRes.paddsb = paddsbVal;
        arithRes.red = {{(aluOpsPkg::dataWidth - aluOpsPkg::redWidth){redSum[aluOpsPkg::redWidth-1]}},
                        redSum};
    end
endmodule

// File: verilog/bitUnit.sv
// Bitwise, shift and byte-load unit
`timescale 1ns/1ps

module bitUnit (
    input  execIfPkg::execReq_t    latchedReq,
    output execIfPkg::bitResults_t bitRes
);
    logic [aluOpsPkg::dataWidth-1:0] rsVal;
    logic [aluOpsPkg::dataWidth-1:0] rtVal;
    logic [aluOpsPkg::shiftAmtWidth-1:0] shiftAmt;
    logic [aluOpsPkg::immWidth-1:0] imm8;
    logic [1:0] digit0;
    logic [1:0] digit1;
    logic [1:0] digit2;

    // one fixed-distance step of the chosen shift
    function automatic logic [aluOpsPkg::dataWidth-1:0] shiftBy(
        input logic [aluOpsPkg::opcodeWidth-1:0] kind,
        input logic [aluOpsPkg::dataWidth-1:0] value,
        input int amount
    );
        logic [aluOpsPkg::dataWidth-1:0] result;
        case (kind)
            aluOpsPkg::opSll: result = value << amount;
            aluOpsPkg::opSra: result = $signed(value) >>> amount;
            aluOpsPkg::opRor: result = (value >> amount) | (value << (aluOpsPkg::dataWidth - amount));
            default: result = value;
        endcase
        return result;
    endfunction

    // digit 0, 1 or 2 times the stage weight
    function automatic logic [aluOpsPkg::dataWidth-1:0] shiftStage(
        input logic [aluOpsPkg::opcodeWidth-1:0] kind,
        input logic [aluOpsPkg::dataWidth-1:0] value,
        input logic [1:0] digit,
        input int weight
    );
        logic [aluOpsPkg::dataWidth-1:0] result;
        case (digit)
            2'd1: result = shiftBy(kind, value, weight);
            2'd2: result = shiftBy(kind, value, 2 * weight);
            default: result = value;
        endcase
        return result;
    endfunction

    function automatic logic [aluOpsPkg::dataWidth-1:0] stagedShift(
        input logic [aluOpsPkg::opcodeWidth-1:0] kind,
        input logic [aluOpsPkg::dataWidth-1:0] value
    );
        logic [aluOpsPkg::dataWidth-1:0] stage1;
        logic [aluOpsPkg::dataWidth-1:0] stage2;
        stage1 = shiftStage(kind, value, digit0, aluOpsPkg::stageWeight0);
        stage2 = shiftStage(kind, stage1, digit1, aluOpsPkg::stageWeight1);
        return shiftStage(kind, stage2, digit2, aluOpsPkg::stageWeight2);
    endfunction

    assign rsVal = latchedReq.rsVal;
    assign rtVal = latchedReq.rtVal;
    assign shiftAmt = latchedReq.instr.regForm.rt;
    assign imm8 = latchedReq.instr.immForm.imm8;

    // shift amount as base-3 digits
    assign digit0 = 2'(shiftAmt % aluOpsPkg::stageBase);
    assign digit1 = 2'((shiftAmt / aluOpsPkg::stageWeight1) % aluOpsPkg::stageBase);
    assign digit2 = 2'(shiftAmt / aluOpsPkg::stageWeight2);

    always_comb begin
        bitRes.xorv = rsVal ^ rtVal;
        bitRes.sll = stagedShift(aluOpsPkg::opSll, rsVal);
        bitRes.sra = stagedShift(aluOpsPkg::opSra, rsVal);
        bitRes.ror = stagedShift(aluOpsPkg::opRor, rsVal);
        // rtVal stands in for the old rd contents
        bitRes.llb = {rtVal[aluOpsPkg::dataWidth-1:aluOpsPkg::byteWidth], imm8};
        bitRes.lhb = {imm8, rtVal[aluOpsPkg::byteWidth-1:0]};
    end
endmodule

// File: verilog/resultSelect.sv
// Opcode result selector
`timescale 1ns/1ps

module resultSelect (
    input  logic [aluOpsPkg::opcodeWidth-1:0] opcode,
    input  execIfPkg::arithResults_t          arithRes,
    input  execIfPkg::bitResults_t            bitRes,
    output execIfPkg::execResp_t              nextResp
);
    always_comb begin
        nextResp = '0;
        case (opcode)
            aluOpsPkg::opAdd: begin
                nextResp.result = arithRes.add;
                nextResp.sat = arithRes.addSat;
            end
            aluOpsPkg::opSub: begin
                nextResp.result = arithRes.sub;
                nextResp.sat = arithRes.subSat;
            end
            aluOpsPkg::opXor: nextResp.result = bitRes.xorv;
            aluOpsPkg::opRed: nextResp.result = arithRes.red;
            aluOpsPkg::opSll: nextResp.result = bitRes.sll;
            aluOpsPkg::opSra: nextResp.result = bitRes.sra;
            aluOpsPkg::opRor: nextResp.result = bitRes.ror;
            aluOpsPkg::opPaddsb: nextResp.result = arithRes.paddsb;
            aluOpsPkg::opLlb: nextResp.result = bitRes.llb;
            aluOpsPkg::opLhb: nextResp.result = bitRes.lhb;
            default: nextResp.result = '0;
        endcase

        // undefined opcodes, result stays zero
        if (opcode > aluOpsPkg::opLastLegal) begin
            nextResp.illegal = 1'b1;
        end
    end
endmodule

// File: verilog/execHandshake.sv
// Four-phase request controller
`timescale 1ns/1ps

module execHandshake (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  execIfPkg::execReq_t  reqData,
    output logic                 ack,
    output execIfPkg::execResp_t resp,
    output execIfPkg::execReq_t  latchedReq,
    input  execIfPkg::execResp_t nextResp
);
    logic [execIfPkg::stateWidth-1:0] state;
    logic accept;

    // new request while idle and the last ack has dropped
    assign accept = (state == execIfPkg::stateIdle) && req && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= execIfPkg::stateIdle;
            ack <= 1'b0;
            resp <= '0;
        end else begin
            case (state)
                execIfPkg::stateIdle: begin
                    if (accept) begin
                        state <= execIfPkg::stateComputing;
                    end
                end
                execIfPkg::stateComputing: begin
                    // units settled on latchedReq, capture the answer
                    resp <= nextResp;
                    ack <= 1'b1;
                    state <= execIfPkg::stateAcked;
                end
                execIfPkg::stateAcked: begin
                    // hold ack and resp until the requester lets go
                    if (!req) begin
                        ack <= 1'b0;
                        state <= execIfPkg::stateIdle;
                    end
                end
                default: state <= execIfPkg::stateIdle;
            endcase
        end
    end

    // operands held for the units while computing
    always_ff @(posedge clk) begin
        if (accept) begin
            latchedReq <= reqData;
        end
    end
endmodule

// File: verilog/aluExecTop.sv
// ALU execute stage top
`timescale 1ns/1ps

module aluExecTop (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  execIfPkg::execReq_t  reqData,
    output logic                 ack,
    output execIfPkg::execResp_t resp
);
    execIfPkg::execReq_t latchedReq;
    execIfPkg::arithResults_t arithRes;
    execIfPkg::bitResults_t bitRes;
    execIfPkg::execResp_t nextResp;

    execHandshake hs0 (
        .clk(clk),
        .rst(rst),
        .req(req),
        .reqData(reqData),
        .ack(ack),
        .resp(resp),
        .latchedReq(latchedReq),
        .nextResp(nextResp)
    );

    arithUnit arith0 (.latchedReq(latchedReq), .arithRes(arithRes));

    bitUnit bits0 (.latchedReq(latchedReq), .bitRes(bitRes));

    resultSelect sel0 (
        .opcode(latchedReq.instr.regForm.opcode),
        .arithRes(arithRes),
        .bitRes(bitRes),
        .nextResp(nextResp)
    );
endmodule

// File: test/aluExec_assert.sv
// Handshake protocol assertions
`timescale 1ns/1ps

module aluExecAssert (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input execIfPkg::execResp_t resp
);
    int failCount = 0;

    ackLowAfterReset: assert property (@(posedge clk) rst |=> !ack)
        else begin
            $error("ack not low after reset");
            failCount++;
        end

    // accept edge, one quiet edge, then ack
    ackLatency: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !ack ##1 !ack ##1 ack)
        else begin
            $error("ack did not rise two edges after accept");
            failCount++;
        end

    ackHeld: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
        else begin
            $error("ack dropped while req was high");
            failCount++;
        end

    respStable: assert property (@(posedge clk) disable iff (rst)
        ack && $past(ack) |-> $stable(resp))
        else begin
            $error("resp changed while ack was high");
            failCount++;
        end

    ackFallAfterReq: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell before req was low");
            failCount++;
        end
endmodule

bind aluExecTop aluExecAssert assert0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .ack(ack),
    .resp(resp)
);

// File: test/aluExecChecker.sv
// Execute stage response checker
`timescale 1ns/1ps

module aluExecChecker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  execIfPkg::execReq_t  reqData,
    input  logic                 ack,
    input  execIfPkg::execResp_t resp,
    output int                   errorCount,
    output int                   respCount
);
    execIfPkg::execReq_t sampledReq;
    execIfPkg::execResp_t expected;
    logic prevReq;
    logic prevAck;

    // {saturated, value} for a 16-bit signed sum
    function automatic logic [16:0] clampWord(input int s);
        if (s > 32767) begin
            return {1'b1, 16'h7fff};
        end
        if (s < -32768) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, 16'(s)};
    endfunction

    function automatic execIfPkg::execResp_t modelResp(input execIfPkg::execReq_t r);
        execIfPkg::execResp_t m;
        int a;
        int b;
        int s;
        logic [3:0] amt;
        logic [31:0] doubled;
        logic signed [3:0] na;
        logic signed [3:0] nb;
        m = '0;
        a = int'($signed(r.rsVal));
        b = int'($signed(r.rtVal));
        amt = r.instr.regForm.rt;
        doubled = {r.rsVal, r.rsVal};
        case (r.instr.regForm.opcode)
            aluOpsPkg::opAdd: {m.sat, m.result} = clampWord(a + b);
            aluOpsPkg::opSub: {m.sat, m.result} = clampWord(a - b);
            aluOpsPkg::opXor: m.result = r.rsVal ^ r.rtVal;
            aluOpsPkg::opRed: begin
                s = int'($signed(r.rsVal[15:8])) + int'($signed(r.rsVal[7:0]))
                  + int'($signed(r.rtVal[15:8])) + int'($signed(r.rtVal[7:0]));
                m.result = 16'(s);
            end
            aluOpsPkg::opSll: m.result = r.rsVal << amt;
            aluOpsPkg::opSra: m.result = $signed(r.rsVal) >>> amt;
            aluOpsPkg::opRor: m.result = doubled[amt +: 16];
            aluOpsPkg::opPaddsb: begin
                for (int i = 0; i < 4; i++) begin
                    na = r.rsVal[4*i +: 4];
                    nb = r.rtVal[4*i +: 4];
                    s = int'(na) + int'(nb);
                    if (s > 7) begin
                        s = 7;
                    end else if (s < -8) begin
                        s = -8;
                    end
                    m.result[4*i +: 4] = 4'(s);
                end
            end
            aluOpsPkg::opLlb: m.result = {r.rtVal[15:8], r.instr.immForm.imm8};
            aluOpsPkg::opLhb: m.result = {r.instr.immForm.imm8, r.rtVal[7:0]};
            default: m.illegal = 1'b1;
        endcase
        return m;
    endfunction

    task automatic compareField(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            prevReq <= 1'b0;
            prevAck <= 1'b0;
            errorCount = 0;
            respCount = 0;
        end else begin
            prevReq <= req;
            prevAck <= ack;
            if (req && !prevReq) begin
                sampledReq <= reqData;
            end
            // first edge that sees the new ack
            if (ack && !prevAck) begin
                expected = modelResp(sampledReq);
                compareField("resp.result", expected.result, resp.result);
                compareField("resp.sat", {15'd0, expected.sat}, {15'd0, resp.sat});
                compareField("resp.illegal", {15'd0, expected.illegal}, {15'd0, resp.illegal});
                respCount++;
            end
        end
    end
endmodule

// File: test/aluExecTb.sv
// ALU execute stage testbench
`timescale 1ns/1ps

module aluExecTb;
    localparam int ackTimeout = 20;
    localparam int randomCount = 400;

    logic clk;
    logic rst;
    logic req;
    execIfPkg::execReq_t reqData;
    logic ack;
    execIfPkg::execResp_t resp;
    int errorCount;
    int respCount;
    int sentCount;
    int timeoutCount;

    aluExecTop dut0 (
        .clk(clk),
        .rst(rst),
        .req(req),
        .reqData(reqData),
        .ack(ack),
        .resp(resp)
    );

    aluExecChecker chk0 (
        .clk(clk),
        .rst(rst),
        .req(req),
        .reqData(reqData),
        .ack(ack),
        .resp(resp),
        .errorCount(errorCount),
        .respCount(respCount)
    );

    always #2 clk = ~clk;

    function automatic execIfPkg::execReq_t randomRequest();
        execIfPkg::execReq_t r;
        r.instr = 16'($urandom);
        r.rsVal = 16'($urandom);
        r.rtVal = 16'($urandom);
        // half the time push both operands to the sign boundary
        if ($urandom_range(1, 0) == 1) begin
            r.rsVal = {($urandom_range(1, 0) == 1) ? 8'h7f : 8'h80, 8'($urandom)};
            r.rtVal = {($urandom_range(1, 0) == 1) ? 8'h7f : 8'h80, 8'($urandom)};
        end
        return r;
    endfunction

    task automatic closeRun();
        int total;
        total = errorCount + dut0.assert0.failCount + timeoutCount;
        if (respCount != sentCount) begin
            $display("responses checked (%0d) differ from requests sent (%0d)",
                     respCount, sentCount);
            total++;
        end
        $display("summary: %0d compare errors, %0d assertion failures, %0d timeouts, %0d responses",
                 errorCount, dut0.assert0.failCount, timeoutCount, respCount);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic waitAck(input logic level, input string what);
        int waited;
        waited = 0;
        while (ack !== level && waited < ackTimeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack !== level) begin
            $display("timeout: ack did not %s for request %0d", what, sentCount);
            timeoutCount++;
            closeRun();
        end
    endtask

    task automatic sendRequest(input execIfPkg::execReq_t r);
        int holdCycles;
        @(posedge clk);
        #1;
        reqData = r;
        req = 1'b1;
        sentCount++;
        waitAck(1'b1, "rise");
        // back-pressure, keep req high a little longer
        holdCycles = $urandom_range(3, 0);
        for (int i = 0; i < holdCycles; i++) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        waitAck(1'b0, "fall");
    endtask

    task automatic shiftSweep(input logic [3:0] op);
        execIfPkg::execReq_t r;
        for (int amt = 0; amt < 16; amt++) begin
            r = randomRequest();
            r.instr.regForm.opcode = op;
            r.instr.regForm.rt = 4'(amt);
            sendRequest(r);
        end
    endtask

    initial begin
        execIfPkg::execReq_t r;
        void'($urandom(32'had303673));
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        reqData = '0;
        sentCount = 0;
        timeoutCount = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // every shift amount for each shift kind
        shiftSweep(aluOpsPkg::opSll);
        shiftSweep(aluOpsPkg::opSra);
        shiftSweep(aluOpsPkg::opRor);

        // undefined opcodes
        for (int op = 10; op < 16; op++) begin
            r = randomRequest();
            r.instr.regForm.opcode = 4'(op);
            sendRequest(r);
        end

        for (int n = 0; n < randomCount; n++) begin
            sendRequest(randomRequest());
        end
        repeat (3) @(posedge clk);
        closeRun();
    end
endmodule

// File: filelist.f
verilog/aluOpsPkg.sv
verilog/execIfPkg.sv
verilog/arithUnit.sv
verilog/bitUnit.sv
verilog/resultSelect.sv
verilog/execHandshake.sv
verilog/aluExecTop.sv
test/aluExec_assert.sv
test/aluExecChecker.sv
test/aluExecTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= aluExecTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= test passed

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv test/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	$(SIM) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
